/* hw/irq_pkg.sv */
package irq_pkg;

    // Basic widths
    typedef logic [31:0] instr_t;
    typedef logic [31:0] addr_t;   // PC or LR value
    typedef logic [1:0]  flags_t;  // Condition flags
    typedef logic [4:0]  opcode_t; // Top five bits of a word
    typedef logic [1:0]  irq_vec_t; // Request line index

    // Context of the special registers, 66 bits
    typedef struct packed {
        addr_t  pc;
        addr_t  lr;
        flags_t fl;
    } cpu_ctx_t;

    // Source of the word sent toward decode
    typedef enum logic [1:0] {
        SEL_FETCH,
        SEL_NOOP,
        SEL_ISR
    } issue_sel_t;

    typedef enum logic [2:0] {
        NORMAL_OPERATION,
        CLEAR_PIPELINE_INT,
        SAVE_REGS,
        ACK_INT,
        INJECTION,
        RESTORE_REGS,
        CLEAR_PIPELINE_RIN
    } irq_state_t;

    localparam instr_t  INSTR_NOOP   = 32'h78000000;
    localparam opcode_t OP_JUMP      = 5'b10100; // Last word of a handler
    localparam opcode_t OP_RIN       = 5'b11111; // Return from interrupt
    localparam opcode_t OP_BODY      = 5'b00010; // Handler body words
    localparam int      CLEAR_CYCLES = 6;        // NOOPs per flush
    localparam int      NUM_IRQ      = 4;
    localparam int      HANDLER_LEN  = 4;

    typedef logic [$clog2(HANDLER_LEN)-1:0] word_idx_t;

    // Start of instruction memory, no flags set
    localparam cpu_ctx_t RESET_CTX = '{pc: 32'h06002000, lr: 32'h06002000, fl: 2'b00};

    // Line k: three body words with low field k*16+i, then a jump with low field k
    localparam instr_t ISR_TABLE [NUM_IRQ][HANDLER_LEN] = '{
        '{{OP_BODY, 27'h000}, {OP_BODY, 27'h001}, {OP_BODY, 27'h002}, {OP_JUMP, 27'h0}},
        '{{OP_BODY, 27'h010}, {OP_BODY, 27'h011}, {OP_BODY, 27'h012}, {OP_JUMP, 27'h1}},
        '{{OP_BODY, 27'h020}, {OP_BODY, 27'h021}, {OP_BODY, 27'h022}, {OP_JUMP, 27'h2}},
        '{{OP_BODY, 27'h030}, {OP_BODY, 27'h031}, {OP_BODY, 27'h032}, {OP_JUMP, 27'h3}}
    };

endpackage

/* hw/irq_ctrl_fsm.sv */
`timescale 1ns/1ps

module irq_ctrl_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                int_req,     // Level from the sequencer
    input  irq_pkg::instr_t     int_instr,   // Current handler word
    input  irq_pkg::instr_t     fetch_instr, // Word from fetch
    output logic                ack,         // One-cycle pulse in ACK_INT
    output logic                save,        // Capture context this cycle
    output logic                restore,     // Saved context valid on bank output
    output irq_pkg::issue_sel_t issue_sel,
    output logic                fetch_hold
);
    import irq_pkg::*;

    irq_state_t state, state_nxt;
    logic [2:0] clr_cnt; // Counts 1 to CLEAR_CYCLES inside a flush
    logic       clr_done;
    logic       is_rin;  // Fetched word returns from interrupt
    logic       is_jump; // Handler word ends the handler

    assign is_rin   = (fetch_instr[31:27] == OP_RIN);
    assign is_jump  = (int_instr[31:27] == OP_JUMP);
    assign clr_done = (clr_cnt == 3'(CLEAR_CYCLES));

    always_comb begin
        // Defaults keep fetch flowing
        state_nxt = state;
        issue_sel = SEL_FETCH;
        ack       = 1'b0;
        save      = 1'b0;
        restore   = 1'b0;

        case (state)
            NORMAL_OPERATION: begin
                // Request wins over a RIN seen in the same cycle
                if (int_req) begin
                    state_nxt = CLEAR_PIPELINE_INT;
                end else if (is_rin) begin
                    state_nxt = CLEAR_PIPELINE_RIN; // RIN itself issues now
                end
            end

            CLEAR_PIPELINE_INT: begin
                issue_sel = SEL_NOOP;
                if (clr_done) begin
                    state_nxt = SAVE_REGS;
                end
            end

            SAVE_REGS: begin
                issue_sel = SEL_NOOP;
                save      = 1'b1; // Bank samples on this edge
                state_nxt = ACK_INT;
            end

            ACK_INT: begin
                issue_sel = SEL_NOOP;
                ack       = 1'b1; // Sequencer picks its line here
                state_nxt = INJECTION;
            end

            INJECTION: begin
                issue_sel = SEL_ISR;
                // Jump word is still issued, then fetch resumes
                if (is_jump) begin
                    state_nxt = NORMAL_OPERATION;
                end
            end

            CLEAR_PIPELINE_RIN: begin
                issue_sel = SEL_NOOP;
                if (clr_done) begin
                    state_nxt = RESTORE_REGS;
                end
            end

            RESTORE_REGS: begin
                issue_sel = SEL_NOOP; // Seventh NOOP of the return
                restore   = 1'b1;
                state_nxt = NORMAL_OPERATION;
            end

            default: begin
                state_nxt = NORMAL_OPERATION;
            end
        endcase
    end

    // Fetch stalls whenever something else is issued
    assign fetch_hold = (issue_sel != SEL_FETCH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= NORMAL_OPERATION;
        end else begin
            state <= state_nxt;
        end
    end

    // Clear counter runs only while staying inside a flush state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clr_cnt <= 3'd1;
        end else if ((state == state_nxt) &&
                     (state == CLEAR_PIPELINE_INT || state == CLEAR_PIPELINE_RIN)) begin
            clr_cnt <= clr_cnt + 3'd1;
        end else begin
            clr_cnt <= 3'd1; // Ready for the next flush
        end
    end

endmodule

/* hw/special_reg_bank.sv */
`timescale 1ns/1ps

module special_reg_bank (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              save,      // From SAVE_REGS
    input  logic              restore,   // From RESTORE_REGS
    input  irq_pkg::cpu_ctx_t cur_ctx,   // Live PC, LR and flags
    output irq_pkg::cpu_ctx_t saved_ctx  // Context before the interrupt
);
    import irq_pkg::*;

    logic save_restore_err; // Sticky, read by the checker

    // Context is captured once per interrupt and held across the handler
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            saved_ctx <= RESET_CTX;
        end else if (save) begin
            saved_ctx <= cur_ctx;
        end
    end

    // Save and restore come from different states, so overlap means a broken FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            save_restore_err <= 1'b0;
        end else if (save && restore) begin
            save_restore_err <= 1'b1;
        end
    end

endmodule

/* hw/isr_sequencer.sv */
`timescale 1ns/1ps

module isr_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [irq_pkg::NUM_IRQ-1:0] irq_lines, // Levels or pulses
    input  logic                        ack,       // Start serving now
    output logic                        int_req,
    output irq_pkg::instr_t             int_instr
);
    import irq_pkg::*;

    logic [NUM_IRQ-1:0] pending;
    logic [NUM_IRQ-1:0] serve_mask; // Bit of the line taken at ack
    logic               busy;       // Streaming a handler
    irq_vec_t           served;
    irq_vec_t           pick;       // Lowest pending line
    word_idx_t          word_idx;

    // Lowest index has priority
    always_comb begin
        pick = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick = irq_vec_t'(i);
            end
        end
    end

    always_comb begin
        serve_mask = '0;
        if (ack) begin
            serve_mask[pick] = 1'b1;
        end
    end

    // Hidden while a handler is streaming
    assign int_req = (|pending) && !busy;

    assign int_instr = busy ? ISR_TABLE[served][word_idx] : INSTR_NOOP;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            // A line still high re-queues itself
            pending <= (pending & ~serve_mask) | irq_lines;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            served   <= '0;
            word_idx <= '0;
        end else if (ack) begin
            busy     <= 1'b1; // Word 0 shows in the next cycle
            served   <= pick;
            word_idx <= '0;
        end else if (busy) begin
            if (word_idx == word_idx_t'(HANDLER_LEN - 1)) begin
                busy <= 1'b0; // Jump word was out this cycle
            end else begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

endmodule

/* hw/instr_issue_stage.sv */
`timescale 1ns/1ps

module instr_issue_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  irq_pkg::issue_sel_t issue_sel,
    input  irq_pkg::instr_t     fetch_instr, // From fetch
    input  irq_pkg::instr_t     int_instr,   // From the sequencer
    output irq_pkg::instr_t     issue_instr  // Toward decode
);
    import irq_pkg::*;

    instr_t sel_instr;

    // Three-way source select
    always_comb begin
        case (issue_sel)
            SEL_FETCH: sel_instr = fetch_instr;
            SEL_ISR:   sel_instr = int_instr;
            default:   sel_instr = INSTR_NOOP; // Flush and save cycles
        endcase
    end

    // Decode sees the chosen word one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_instr <= INSTR_NOOP; // Pipeline starts empty
        end else begin
            issue_instr <= sel_instr;
        end
    end

endmodule

/* hw/irq_subsystem_top.sv */
`timescale 1ns/1ps

module irq_subsystem_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  irq_pkg::instr_t             fetch_instr,
    input  irq_pkg::cpu_ctx_t           cur_ctx,
    input  logic [irq_pkg::NUM_IRQ-1:0] irq_lines,
    output irq_pkg::instr_t             issue_instr,
    output logic                        fetch_hold,
    output logic                        restore,
    output irq_pkg::cpu_ctx_t           saved_ctx
);
    import irq_pkg::*;

    logic       int_req;   // Sequencer has work
    instr_t     int_instr; // Handler word or NOOP
    logic       ack;
    logic       save;
    issue_sel_t issue_sel;

    irq_ctrl_fsm u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .int_req     (int_req),
        .int_instr   (int_instr),
        .fetch_instr (fetch_instr),
        .ack         (ack),
        .save        (save),
        .restore     (restore),
        .issue_sel   (issue_sel),
        .fetch_hold  (fetch_hold)
    );

    special_reg_bank u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .save      (save),
        .restore   (restore),
        .cur_ctx   (cur_ctx),
        .saved_ctx (saved_ctx)
    );

    isr_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .irq_lines (irq_lines),
        .ack       (ack),
        .int_req   (int_req),
        .int_instr (int_instr)
    );

    // Registered select toward decode
    instr_issue_stage u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_sel   (issue_sel),
        .fetch_instr (fetch_instr),
        .int_instr   (int_instr),
        .issue_instr (issue_instr)
    );

endmodule

/* verif/irq_subsystem_chk.sv */
`timescale 1ns/1ps

module irq_subsystem_chk (
    input logic                clk,
    input logic                rst_n,
    input logic                ack,
    input logic                restore,
    input irq_pkg::issue_sel_t issue_sel,
    input irq_pkg::instr_t     int_instr,   // Sequencer word
    input irq_pkg::instr_t     fetch_instr, // Word from fetch
    input irq_pkg::instr_t     issue_instr, // Registered word toward decode
    input logic                fetch_hold,
    input logic                bank_err     // Sticky save/restore overlap flag
);
    import irq_pkg::*;

    int fail_cnt; // Failed assertions so far

    initial fail_cnt = 0;

    // Ack comes from the single ACK_INT cycle
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        ack |=> !ack)
        else begin
            fail_cnt++;
            $error("ack held high for more than one cycle");
        end

    restore_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        restore |=> !restore)
        else begin
            fail_cnt++;
            $error("restore held high for more than one cycle");
        end

    // Handler word lands in the issue register one clock later
    isr_word_issued: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_sel == SEL_ISR) |=> (issue_instr == $past(int_instr)))
        else begin
            fail_cnt++;
            $error("handler word not issued after ISR select");
        end

    // Fetch not held means the fetched word reaches decode next clock
    fetch_word_issued: assert property (@(posedge clk) disable iff (!rst_n)
        !fetch_hold |=> (issue_instr == $past(fetch_instr)))
        else begin
            fail_cnt++;
            $error("fetched word not issued while fetch_hold was low");
        end

    bank_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !bank_err)
        else begin
            fail_cnt++;
            $error("save and restore seen in the same cycle");
        end

endmodule

bind irq_subsystem_top irq_subsystem_chk chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .ack         (ack),
    .restore     (restore),
    .issue_sel   (issue_sel),
    .int_instr   (int_instr),
    .fetch_instr (fetch_instr),
    .issue_instr (issue_instr),
    .fetch_hold  (fetch_hold),
    .bank_err    (u_regs.save_restore_err)
);

/* verif/irq_subsystem_tb.sv */
`timescale 1ns/1ps

module irq_subsystem_tb;
    import irq_pkg::*;

    // Phases of the reference model of the issued stream
    typedef enum logic [1:0] {
        M_RUN,
        M_IFLUSH,
        M_INJECT,
        M_RFLUSH
    } model_mode_t;

    logic        clk;
    logic        rst_n;
    instr_t      fetch_instr;
    cpu_ctx_t    cur_ctx;
    logic [3:0]  irq_lines;
    instr_t      issue_instr;
    logic        fetch_hold;
    logic        restore;
    cpu_ctx_t    saved_ctx;

    logic [31:0] lcg_state;
    string       test_name;
    int          err_cnt;
    int          tests_failed;
    int          restore_cnt;  // Restore pulses seen on the DUT
    int          flush_cnt;    // Flushes begun by the DUT
    logic        hold_prev;    // fetch_hold one cycle back
    logic [26:0] jump_seen[$]; // Low fields of issued jump words

    model_mode_t m_mode;
    int          m_cnt;        // Cycles spent in the current flush
    logic [3:0]  m_pend;
    logic        m_busy;       // Handler streaming
    int          m_line;
    int          m_idx;
    cpu_ctx_t    m_saved;

    irq_subsystem_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_instr (fetch_instr),
        .cur_ctx     (cur_ctx),
        .irq_lines   (irq_lines),
        .issue_instr (issue_instr),
        .fetch_hold  (fetch_hold),
        .restore     (restore),
        .saved_ctx   (saved_ctx)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk; // 10 ns period

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Random fetch word that never carries RIN or jump
    function automatic instr_t rand_word();
        instr_t w;
        w = lcg_next();
        if (w[31:27] == OP_RIN || w[31:27] == OP_JUMP) begin
            w[31:27] = 5'b00011;
        end
        return w;
    endfunction

    // Word idx of the handler for request line 'line'
    function automatic instr_t handler_word(int line, int idx);
        if (idx == 3) begin
            return {5'b10100, 27'(line)}; // Jump closes the handler
        end
        return {5'b00010, 27'(line * 16 + idx)};
    endfunction

    task automatic check_val(string what, logic [65:0] exp, logic [65:0] act);
        assert (act == exp) else begin
            err_cnt++;
            $display("ERROR: %s: %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // One clock of the model, called at 1 ns after the rising edge
    task automatic advance_model();
        instr_t      exp_word;
        logic        exp_restore;
        logic        exp_hold;
        logic        int_req;
        logic [3:0]  served;
        model_mode_t nxt_mode;
        int          i;

        int_req     = (|m_pend) && !m_busy;
        exp_word    = INSTR_NOOP;
        exp_restore = 1'b0;
        exp_hold    = 1'b1;
        served      = 4'b0;
        nxt_mode    = m_mode;
        case (m_mode)
            M_RUN: begin
                exp_word = fetch_instr; // Passes through, RIN included
                exp_hold = 1'b0;
                m_cnt    = 0;
                if (int_req) begin
                    nxt_mode = M_IFLUSH;
                end else if (fetch_instr[31:27] == OP_RIN) begin
                    nxt_mode = M_RFLUSH;
                end
            end
            M_IFLUSH: begin
                if (m_cnt == CLEAR_CYCLES) begin
                    m_saved = cur_ctx; // Save cycle
                end else if (m_cnt == CLEAR_CYCLES + 1) begin
                    for (i = 3; i >= 0; i--) begin
                        if (m_pend[i]) begin
                            m_line = i; // Lowest pending line wins
                        end
                    end
                    served[m_line] = 1'b1;
                    m_busy   = 1'b1;
                    m_idx    = 0;
                    nxt_mode = M_INJECT;
                end
                m_cnt++;
            end
            M_INJECT: begin
                exp_word = handler_word(m_line, m_idx);
                if (m_idx == 3) begin
                    m_busy   = 1'b0;
                    nxt_mode = M_RUN;
                end else begin
                    m_idx++;
                end
            end
            default: begin
                if (m_cnt == CLEAR_CYCLES) begin
                    exp_restore = 1'b1; // Seventh NOOP of the return
                    nxt_mode    = M_RUN;
                end
                m_cnt++;
            end
        endcase
        check_val("restore", exp_restore, restore);
        check_val("fetch_hold", exp_hold, fetch_hold);
        if (restore) begin
            restore_cnt++;
        end
        if (fetch_hold && !hold_prev) begin
            flush_cnt++; // Hold rises at the first clear cycle
        end
        hold_prev = fetch_hold;
        m_pend = (m_pend & ~served) | irq_lines; // Lines seen at this edge
        m_mode = nxt_mode;
        @(posedge clk);
        #1;
        check_val("issue_instr", exp_word, issue_instr);
        check_val("saved_ctx", m_saved, saved_ctx);
        if (issue_instr[31:27] == OP_JUMP) begin
            jump_seen.push_back(issue_instr[26:0]);
        end
    endtask

    task automatic drive_cycle(instr_t word, logic [3:0] lines);
        fetch_instr = word;
        irq_lines   = lines;
        advance_model();
    endtask

    // Quiet cycles until fetch flows again with nothing pending
    task automatic run_until_idle(int limit);
        int n;
        n = 0;
        while (fetch_hold || m_mode != M_RUN || m_pend != 4'b0) begin
            if (n == limit) begin
                err_cnt++;
                $display("Timeout: %s did not return to normal fetch within %0d cycles",
                         test_name, limit);
                break;
            end
            drive_cycle(rand_word(), 4'b0);
            n++;
        end
    endtask

    task automatic end_test(int start_err);
        if (err_cnt != start_err) begin
            tests_failed++;
        end
        $display("[%s] finished with %0d error(s)", test_name, err_cnt - start_err);
    endtask

    initial begin
        cpu_ctx_t    entry_ctx;
        int          start_err;
        int          n;
        logic [31:0] r;
        instr_t      word;

        lcg_state    = 32'h54ce;
        err_cnt      = 0;
        tests_failed = 0;
        restore_cnt  = 0;
        flush_cnt    = 0;
        hold_prev    = 1'b0;
        rst_n        = 1'b0;
        fetch_instr  = INSTR_NOOP;
        cur_ctx      = '0;
        irq_lines    = 4'b0;
        m_mode       = M_RUN;
        m_cnt        = 0;
        m_pend       = 4'b0;
        m_busy       = 1'b0;
        m_line       = 0;
        m_idx        = 0;
        m_saved      = RESET_CTX;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_name = "reset";
        start_err = err_cnt;
        check_val("issue_instr", INSTR_NOOP, issue_instr);
        check_val("saved_ctx", RESET_CTX, saved_ctx);
        check_val("restore", 1'b0, restore);
        check_val("fetch_hold", 1'b0, fetch_hold);
        end_test(start_err);

        test_name = "passthrough";
        start_err = err_cnt;
        repeat (50) drive_cycle(rand_word(), 4'b0);
        end_test(start_err);

        test_name = "irq_entry";
        start_err = err_cnt;
        entry_ctx = {lcg_next(), lcg_next(), 2'b10};
        cur_ctx   = entry_ctx; // Steady across the whole entry
        jump_seen.delete();
        drive_cycle(rand_word(), 4'b0100); // One-cycle pulse on line 2
        run_until_idle(40);
        check_val("saved_ctx", entry_ctx, saved_ctx);
        check_val("jump words", 1, jump_seen.size());
        repeat (5) drive_cycle(rand_word(), 4'b0);
        end_test(start_err);

        test_name = "return";
        start_err = err_cnt;
        cur_ctx     = {lcg_next(), lcg_next(), 2'b01}; // Live context moves on
        restore_cnt = 0;
        word        = lcg_next();
        drive_cycle({OP_RIN, word[26:0]}, 4'b0);
        run_until_idle(20);
        check_val("restore pulses", 1, restore_cnt);
        check_val("saved_ctx", entry_ctx, saved_ctx);
        repeat (5) drive_cycle(rand_word(), 4'b0);
        end_test(start_err);

        test_name = "priority";
        start_err = err_cnt;
        jump_seen.delete();
        flush_cnt = 0;
        drive_cycle(rand_word(), 4'b1010); // Lines 3 and 1 together
        run_until_idle(60);
        check_val("flushes", 2, flush_cnt);
        check_val("jump words", 2, jump_seen.size());
        if (jump_seen.size() == 2) begin
            check_val("first handler", 1, jump_seen[0]);
            check_val("second handler", 3, jump_seen[1]);
        end
        end_test(start_err);

        test_name = "random_mix";
        start_err = err_cnt;
        for (n = 0; n < 200; n++) begin
            r       = lcg_next();
            cur_ctx = {lcg_next(), lcg_next(), r[1:0]};
            word    = (r[19:16] == 4'h0) ? {OP_RIN, r[26:0]} : rand_word(); // RIN 1 in 16
            drive_cycle(word, (r[23:20] < 4'h3) ? r[27:24] : 4'b0);
        end
        run_until_idle(200);
        end_test(start_err);

        // Concurrent assertion failures from the bound checker
        err_cnt = err_cnt + dut.chk.fail_cnt;
        $display("Tests run: 6, failed: %0d, errors: %0d, assertion failures: %0d",
                 tests_failed, err_cnt, dut.chk.fail_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* irq_subsystem_top.f */
hw/irq_pkg.sv
hw/irq_ctrl_fsm.sv
hw/special_reg_bank.sv
hw/isr_sequencer.sv
hw/instr_issue_stage.sv
hw/irq_subsystem_top.sv
verif/irq_subsystem_chk.sv
verif/irq_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the interrupt front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module irq_subsystem_tb \
    -f irq_subsystem_top.f \
    -Mdir obj_dir -o sim_irq
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_irq)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
